// ==== src/bitser_macros.svh ====
`ifndef BITSER_MACROS_SVH
`define BITSER_MACROS_SVH

// data path and instruction word width
`define BITSER_XLEN   32
// opcode field at the top of every instruction word
`define BITSER_OP_W   4
// register count and the width of a register index
`define BITSER_NREGS  8
`define BITSER_RIDX_W 3
// signed immediate held in the low bits of the immediate format
`define BITSER_IMM_W  22
// upper part of the bit counter
// the two low index bits are encoded by a 4-bit one-hot ring
`define BITSER_CNT_W  3
// full serial bit index, upper count plus the two ring bits
`define BITSER_IDX_W  5

`endif

// ==== src/bitser_pkg.sv ====
`include "bitser_macros.svh"

package bitser_pkg;

   // opcode values in bits [31:28] of the instruction word
   // anything above OUT is executed as a no-op
   typedef enum logic [`BITSER_OP_W-1:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      OR   = 4'd3,
      XOR  = 4'd4,
      SLT  = 4'd5,
      ADDI = 4'd6,
      XORI = 4'd7,
      BEQ  = 4'd8,
      BNE  = 4'd9,
      OUT  = 4'd10
   } bitser_op_e;

   // register format with three register indices
   typedef struct packed {
      bitser_op_e                  opcode;
      logic [`BITSER_RIDX_W-1:0]   rd;
      logic [`BITSER_RIDX_W-1:0]   rs1;
      logic [`BITSER_RIDX_W-1:0]   rs2;
      logic [`BITSER_XLEN-`BITSER_OP_W-3*`BITSER_RIDX_W-1:0] unused;
   } bitser_rtype_s;

   // immediate format, the immediate overlaps the rs2 field
   typedef struct packed {
      bitser_op_e                       opcode;
      logic [`BITSER_RIDX_W-1:0]        rd;
      logic [`BITSER_RIDX_W-1:0]        rs1;
      logic signed [`BITSER_IMM_W-1:0]  imm;
   } bitser_itype_s;

   // one fetched word seen through both formats
   // rs2 is taken from the r view and the immediate from the i view
   typedef union packed {
      bitser_rtype_s r;
      bitser_itype_s i;
   } bitser_insn_u;

endpackage

// ==== src/bitser_decode.sv ====
`timescale 1ns/1ps
`include "bitser_macros.svh"

module bitser_decode
   import bitser_pkg::*;
(
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_ibus_ack,
   input  logic [`BITSER_XLEN-1:0]   i_ibus_rdt,
   input  logic [`BITSER_IDX_W-1:0]  i_cnt_idx,
   output logic [`BITSER_RIDX_W-1:0] o_rs1,
   output logic [`BITSER_RIDX_W-1:0] o_rs2,
   output logic [`BITSER_RIDX_W-1:0] o_rd,
   output logic [`BITSER_IMM_W-1:0]  o_imm,
   output logic                      o_imm_bit,
   output logic                      o_branch,
   output logic                      o_bne,
   output logic                      o_two_stage,
   output logic                      o_write_rd,
   output logic                      o_imm_sel,
   output logic                      o_out_op,
   output bitser_op_e                o_alu_fn
);

   bitser_insn_u            insn_q;
   bitser_op_e              op;
   logic [`BITSER_XLEN-1:0] imm_ext;

   // the word is held for the whole instruction, both passes included
   // a cleared word decodes as an add into r0 and so changes nothing
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         insn_q <= '0;
      end else if (i_ibus_ack) begin
         insn_q <= i_ibus_rdt;
      end
   end

   assign op    = insn_q.r.opcode;
   assign o_rs1 = insn_q.r.rs1;
   assign o_rd  = insn_q.r.rd;
   // branches compare rs1 with the register named in the rd field
   assign o_rs2 = o_branch ? insn_q.r.rd : insn_q.r.rs2;
   assign o_imm = insn_q.i.imm;

   // sign extend once so the serial bit is a plain index into the word
   assign imm_ext = {{(`BITSER_XLEN-`BITSER_IMM_W){insn_q.i.imm[`BITSER_IMM_W-1]}},
                     insn_q.i.imm};
   assign o_imm_bit = imm_ext[i_cnt_idx];

   always_comb begin
      o_branch    = 1'b0;
      o_bne       = 1'b0;
      o_two_stage = 1'b0;
      o_write_rd  = 1'b0;
      o_imm_sel   = 1'b0;
      o_out_op    = 1'b0;
      o_alu_fn    = ADD;
      case (op)
         ADD, SUB, AND, OR, XOR: begin
            o_write_rd = 1'b1;
            o_alu_fn   = op;
         end
         // compare in the first pass, write the flag in the second
         SLT: begin
            o_write_rd  = 1'b1;
            o_two_stage = 1'b1;
            o_alu_fn    = SLT;
         end
         ADDI: begin
            o_write_rd = 1'b1;
            o_imm_sel  = 1'b1;
         end
         XORI: begin
            o_write_rd = 1'b1;
            o_imm_sel  = 1'b1;
            o_alu_fn   = XOR;
         end
         // only the equality flag of the alu is looked at for branches
         BEQ, BNE: begin
            o_branch    = 1'b1;
            o_two_stage = 1'b1;
            o_bne       = (op == BNE);
            o_alu_fn    = SUB;
         end
         OUT: o_out_op = 1'b1;
         // unknown opcodes still run one pass and step the PC
         default: ;
      endcase
   end

endmodule

// ==== src/bitser_state.sv ====
`timescale 1ns/1ps
`include "bitser_macros.svh"

module bitser_state (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  logic                     i_ibus_ack,
   output logic                     o_ibus_cyc,
   output logic [`BITSER_XLEN-1:0]  o_ibus_adr,
   input  logic                     i_branch,
   input  logic                     i_bne,
   input  logic                     i_two_stage,
   input  logic                     i_write_rd,
   input  logic                     i_out_op,
   input  logic                     i_alu_eq,
   input  logic [`BITSER_IMM_W-1:0] i_imm,
   output logic                     o_cnt_en,
   output logic [`BITSER_IDX_W-1:0] o_cnt_idx,
   output logic                     o_cnt0,
   output logic                     o_cnt_done,
   output logic                     o_init,
   output logic                     o_rd_en,
   output logic                     o_out_strobe
);

   localparam logic [`BITSER_XLEN-1:0] PC_STEP = 4;

   logic [`BITSER_CNT_W-1:0] cnt_hi;
   logic [3:0]               cnt_r;
   logic                     init_done;
   logic                     stage_two_req;
   logic                     boot;
   logic                     take_branch;
   logic                     pc_upd;
   logic [`BITSER_XLEN-1:0]  pc;
   logic [`BITSER_XLEN-1:0]  br_off;

   // the counter runs whenever a ring bit is set, no separate enable flop
   assign o_cnt_en  = |cnt_r;
   // one-hot ring position encoded into the two low index bits
   assign o_cnt_idx = {cnt_hi, cnt_r[3] | cnt_r[2], cnt_r[3] | cnt_r[1]};
   assign o_cnt0    = (cnt_hi == '0) & cnt_r[0];

   // first pass of slt or a branch, cleared once that pass has finished
   assign o_init  = i_two_stage & !init_done;
   // the first pass only computes flags and never writes rd
   assign o_rd_en = i_write_rd & o_cnt_en & !o_init;

   // the output buffer is complete on the last bit of the OUT pass
   assign o_out_strobe = o_cnt_done & i_out_op;

   // i_alu_eq includes bit 31 while o_cnt_done is high
   assign take_branch = i_branch & (i_alu_eq ^ i_bne);
   // branches finish after their first pass, slt needs its second one
   assign pc_upd      = o_cnt_done & (!o_init | i_branch);

   // immediate counts words, so shift it up by two
   assign br_off = {{(`BITSER_XLEN-`BITSER_IMM_W-2){i_imm[`BITSER_IMM_W-1]}}, i_imm, 2'b00};

   assign o_ibus_adr = pc;

   always_ff @(posedge i_clk) begin
      // delayed reset, marks the first cycle after reset is released
      boot <= i_rst;
      if (i_rst) begin
         o_ibus_cyc    <= 1'b0;
         pc            <= '0;
         cnt_hi        <= '0;
         cnt_r         <= 4'b0000;
         o_cnt_done    <= 1'b0;
         init_done     <= 1'b0;
         stage_two_req <= 1'b0;
      end else begin
         // fetch starts after reset and after each PC update
         // the acknowledge closes the bus cycle
         if (boot | pc_upd) begin
            o_ibus_cyc <= 1'b1;
         end else if (i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end

         if (pc_upd) begin
            pc <= pc + (take_branch ? br_off : PC_STEP);
         end

         if (o_cnt_done) begin
            init_done <= o_init & !i_branch;
         end
         // one-cycle request that launches the second slt pass
         stage_two_req <= o_cnt_done & o_init & !i_branch;

         // registered so that it is high during bit 31
         o_cnt_done <= (cnt_hi == '1) & cnt_r[2];

         // upper count steps each time the ring wraps past position 3
         cnt_hi <= cnt_hi + {{(`BITSER_CNT_W-1){1'b0}}, cnt_r[3]};
         // a new pass is injected at bit 0 of the ring when idle
         // and the done flag stops the ring from wrapping after bit 31
         cnt_r  <= {cnt_r[2:0],
                    (cnt_r[3] & !o_cnt_done) | ((i_ibus_ack | stage_two_req) & !o_cnt_en)};
      end
   end

endmodule

// ==== src/bitser_alu.sv ====
`timescale 1ns/1ps
`include "bitser_macros.svh"

module bitser_alu
   import bitser_pkg::*;
(
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  logic                     i_cnt_en,
   input  logic                     i_cnt0,
   input  logic                     i_rs1_bit,
   input  logic                     i_rs2_bit,
   input  logic                     i_imm_bit,
   input  logic                     i_imm_sel,
   input  bitser_op_e               i_alu_fn,
   input  logic                     i_init,
   input  logic [`BITSER_IDX_W-1:0] i_cnt_idx,
   output logic                     o_rd_bit,
   output logic                     o_eq,
   output logic                     o_lt
);

   logic op2;
   logic sub_mode;
   logic b_eff;
   logic cin;
   logic sum;
   logic cout;
   logic carry_q;
   logic eq_q;
   logic last_bit;

   // second operand is either register rs2 or the serial immediate
   assign op2      = i_imm_sel ? i_imm_bit : i_rs2_bit;
   // slt compares by subtracting in its first pass
   assign sub_mode = (i_alu_fn == SUB) | (i_alu_fn == SLT);

   // subtract as a + ~b + 1, the +1 enters as carry in at bit 0
   assign b_eff = op2 ^ sub_mode;
   assign cin   = i_cnt0 ? sub_mode : carry_q;
   assign sum   = i_rs1_bit ^ b_eff ^ cin;
   assign cout  = (i_rs1_bit & b_eff) | (cin & (i_rs1_bit ^ b_eff));

   // equality including the current bit, so it is final on bit 31
   assign o_eq = (i_cnt0 | eq_q) & !(i_rs1_bit ^ op2);

   assign last_bit = &i_cnt_idx;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
         o_lt    <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= cout;
         eq_q    <= o_eq;
         // with equal signs the missing borrow decides
         // otherwise rs1 is smaller exactly when it is negative
         if (i_init & last_bit) begin
            o_lt <= (i_rs1_bit ^ op2) ? i_rs1_bit : !cout;
         end
      end
   end

   always_comb begin
      case (i_alu_fn)
         AND:     o_rd_bit = i_rs1_bit & op2;
         OR:      o_rd_bit = i_rs1_bit | op2;
         XOR:     o_rd_bit = i_rs1_bit ^ op2;
         // second pass writes the flag at bit 0 and zero above it
         SLT:     o_rd_bit = i_init ? sum : (i_cnt0 & o_lt);
         default: o_rd_bit = sum;
      endcase
   end

endmodule

// ==== src/bitser_regfile.sv ====
`timescale 1ns/1ps
`include "bitser_macros.svh"

module bitser_regfile (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic [`BITSER_RIDX_W-1:0] i_rs1,
   input  logic [`BITSER_RIDX_W-1:0] i_rs2,
   input  logic [`BITSER_RIDX_W-1:0] i_rd,
   input  logic [`BITSER_IDX_W-1:0]  i_cnt_idx,
   input  logic                      i_rd_en,
   input  logic                      i_rd_bit,
   input  logic                      i_out_strobe,
   output logic                      o_rs1_bit,
   output logic                      o_rs2_bit,
   output logic                      o_out_valid,
   output logic [`BITSER_XLEN-1:0]   o_out_data
);

   logic [`BITSER_XLEN-1:0] regs [`BITSER_NREGS];
   logic [`BITSER_XLEN-1:0] rs1_word;
   logic [`BITSER_XLEN-1:0] rs2_word;
   logic [`BITSER_XLEN-1:0] out_shift;

   assign rs1_word = regs[i_rs1];
   assign rs2_word = regs[i_rs2];

   // register 0 is never written and is forced to read as zero
   assign o_rs1_bit = (i_rs1 != '0) & rs1_word[i_cnt_idx];
   assign o_rs2_bit = (i_rs2 != '0) & rs2_word[i_cnt_idx];

   // each bit is read before it is written
   // so rd may name one of the sources
   always_ff @(posedge i_clk) begin
      if (i_rd_en && (i_rd != '0)) begin
         regs[i_rd][i_cnt_idx] <= i_rd_bit;
      end
   end

   // rs1 bits enter from the top, so after 32 shifts bit 0 is at the bottom
   // the last bit is merged in directly when the strobe arrives
   always_ff @(posedge i_clk) begin
      out_shift <= {o_rs1_bit, out_shift[`BITSER_XLEN-1:1]};
      if (i_out_strobe) begin
         o_out_data <= {o_rs1_bit, out_shift[`BITSER_XLEN-1:1]};
      end
   end

   // one-cycle valid, the cycle after the last bit of the OUT pass
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_out_valid <= 1'b0;
      end else begin
         o_out_valid <= i_out_strobe;
      end
   end

endmodule

// ==== src/bitser_top.sv ====
`timescale 1ns/1ps
`include "bitser_macros.svh"

module bitser_top
   import bitser_pkg::*;
(
   input  logic                     i_clk,
   input  logic                     i_rst,
   output logic                     o_ibus_cyc,
   output logic [`BITSER_XLEN-1:0]  o_ibus_adr,
   input  logic                     i_ibus_ack,
   input  logic [`BITSER_XLEN-1:0]  i_ibus_rdt,
   output logic                     o_out_valid,
   output logic [`BITSER_XLEN-1:0]  o_out_data
);

   // decode outputs
   logic [`BITSER_RIDX_W-1:0] rs1;
   logic [`BITSER_RIDX_W-1:0] rs2;
   logic [`BITSER_RIDX_W-1:0] rd;
   logic [`BITSER_IMM_W-1:0]  imm;
   logic                      imm_bit;
   logic                      branch;
   logic                      bne;
   logic                      two_stage;
   logic                      write_rd;
   logic                      imm_sel;
   logic                      out_op;
   bitser_op_e                alu_fn;

   // sequencing from the state block
   logic                      cnt_en;
   logic [`BITSER_IDX_W-1:0]  cnt_idx;
   logic                      cnt0;
   logic                      init;
   logic                      rd_en;
   logic                      out_strobe;

   // serial data path
   logic                      rs1_bit;
   logic                      rs2_bit;
   logic                      rd_bit;
   logic                      alu_eq;

   bitser_decode decode0 (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_cnt_idx   (cnt_idx),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_rd        (rd),
      .o_imm       (imm),
      .o_imm_bit   (imm_bit),
      .o_branch    (branch),
      .o_bne       (bne),
      .o_two_stage (two_stage),
      .o_write_rd  (write_rd),
      .o_imm_sel   (imm_sel),
      .o_out_op    (out_op),
      .o_alu_fn    (alu_fn)
   );

   // the end of a pass is only acted on inside the state block
   bitser_state state0 (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_ibus_ack   (i_ibus_ack),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_ibus_adr   (o_ibus_adr),
      .i_branch     (branch),
      .i_bne        (bne),
      .i_two_stage  (two_stage),
      .i_write_rd   (write_rd),
      .i_out_op     (out_op),
      .i_alu_eq     (alu_eq),
      .i_imm        (imm),
      .o_cnt_en     (cnt_en),
      .o_cnt_idx    (cnt_idx),
      .o_cnt0       (cnt0),
      .o_cnt_done   (),
      .o_init       (init),
      .o_rd_en      (rd_en),
      .o_out_strobe (out_strobe)
   );

   // the less-than flag is consumed inside the alu by the second slt pass
   bitser_alu alu0 (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .i_imm_sel (imm_sel),
      .i_alu_fn  (alu_fn),
      .i_init    (init),
      .i_cnt_idx (cnt_idx),
      .o_rd_bit  (rd_bit),
      .o_eq      (alu_eq),
      .o_lt      ()
   );

   bitser_regfile regfile0 (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_rs1        (rs1),
      .i_rs2        (rs2),
      .i_rd         (rd),
      .i_cnt_idx    (cnt_idx),
      .i_rd_en      (rd_en),
      .i_rd_bit     (rd_bit),
      .i_out_strobe (out_strobe),
      .o_rs1_bit    (rs1_bit),
      .o_rs2_bit    (rs2_bit),
      .o_out_valid  (o_out_valid),
      .o_out_data   (o_out_data)
   );

endmodule

// ==== verif/bitser_tb.sv ====
`timescale 1ns/1ps
`include "bitser_macros.svh"

module bitser_tb
   import bitser_pkg::*;
();

   localparam int NUM_RANDOM    = 400;
   localparam int NUM_SEED_REGS = 7;
   // slt with two passes is the longest instruction, far below this
   localparam int WAIT_LIMIT    = 200;

   logic                    i_clk;
   logic                    i_rst;
   logic                    i_ibus_ack;
   logic [`BITSER_XLEN-1:0] i_ibus_rdt;
   logic                    o_ibus_cyc;
   logic [`BITSER_XLEN-1:0] o_ibus_adr;
   logic                    o_out_valid;
   logic [`BITSER_XLEN-1:0] o_out_data;

   integer                  seed;
   int                      mismatch_cnt;
   int                      protocol_cnt;
   int                      timeout_cnt;
   logic                    aborted;
   // output strobes seen since the last acknowledge
   int                      out_seen;
   int                      out_expected_cnt;
   logic [`BITSER_XLEN-1:0] out_expected_data;
   // reference model state
   logic [`BITSER_XLEN-1:0] model_pc;
   logic [`BITSER_XLEN-1:0] model_regs [`BITSER_NREGS];
   // an slt is always followed by an OUT of its destination
   logic                    slt_pending;
   logic [2:0]              slt_rd;

   bitser_top dut0 (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_ibus_adr  (o_ibus_adr),
      .i_ibus_ack  (i_ibus_ack),
      .i_ibus_rdt  (i_ibus_rdt),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data)
   );

   always #10 i_clk = ~i_clk;

   // outputs are sampled and inputs driven 2 ns after each rising edge
   task tick;
      @(posedge i_clk);
      #2;
      if (o_out_valid === 1'b1) begin
         out_seen = out_seen + 1;
      end
   endtask

   task wait_fetch;
      int n;
      n = 0;
      while (o_ibus_cyc !== 1'b1 && n < WAIT_LIMIT) begin
         tick();
         n = n + 1;
      end
      if (o_ibus_cyc !== 1'b1) begin
         $display("ERROR: timeout waiting for o_ibus_cyc at %0t", $time);
         timeout_cnt = timeout_cnt + 1;
         aborted = 1'b1;
      end
   endtask

   task wait_out_valid;
      int n;
      n = 0;
      while (o_out_valid !== 1'b1 && n < WAIT_LIMIT) begin
         tick();
         n = n + 1;
      end
      if (o_out_valid !== 1'b1) begin
         $display("ERROR: OUT instruction gave no o_out_valid strobe at %0t", $time);
         timeout_cnt = timeout_cnt + 1;
         aborted = 1'b1;
      end else if (o_out_data !== out_expected_data) begin
         $display("MISMATCH o_out_data: got %h expected %h at %0t",
                  o_out_data, out_expected_data, $time);
         mismatch_cnt = mismatch_cnt + 1;
      end
   endtask

   // exactly one strobe after an OUT and none after anything else
   task check_out_count;
      if (out_seen != out_expected_cnt) begin
         $display("ERROR: %0d o_out_valid strobes seen, %0d expected, at %0t",
                  out_seen, out_expected_cnt, $time);
         protocol_cnt = protocol_cnt + 1;
      end
   endtask

   task check_fetch_adr;
      if (o_ibus_adr !== model_pc) begin
         $display("MISMATCH o_ibus_adr: got %h expected %h at %0t",
                  o_ibus_adr, model_pc, $time);
         mismatch_cnt = mismatch_cnt + 1;
      end
   endtask

   // the prologue gives r1..r7 known values, odd registers negative
   task make_seed_word(input int k, output logic [31:0] word);
      logic [31:0] rnd;
      logic [3:0]  op;
      rnd  = $random(seed);
      op   = ADDI;
      word = {op, k[2:0], 3'd0, k[0], rnd[20:0]};
   endtask

   task make_word(output logic [31:0] word);
      logic [31:0] r1;
      logic [31:0] r2;
      logic [3:0]  op;
      r1 = $random(seed);
      r2 = $random(seed);
      if (slt_pending) begin
         op          = OUT;
         word        = {op, 3'd0, slt_rd, r2[21:0]};
         slt_pending = 1'b0;
      end else begin
         // roughly a fifth of the stream is OUT, opcodes 11..15 are no-ops
         if (r1[4:0] < 5'd6) begin
            op = OUT;
         end else begin
            op = r1[8:5];
         end
         // branch offsets stay within -4..+3 words
         if (op == BEQ || op == BNE) begin
            word = {op, r1[11:9], r1[14:12], {19{r2[2]}}, r2[2:0]};
         end else begin
            word = {op, r1[11:9], r1[14:12], r2[21:0]};
         end
         if (op == SLT) begin
            slt_pending = 1'b1;
            slt_rd      = r1[11:9];
         end
      end
   endtask

   // reference model, one whole instruction at a time
   task model_step(input logic [31:0] word);
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] imm;
      logic [31:0] res;
      logic        wr;
      logic [31:0] next_pc;
      op      = word[31:28];
      rd      = word[27:25];
      a       = model_regs[word[24:22]];
      b       = model_regs[word[21:19]];
      c       = model_regs[rd];
      imm     = {{10{word[21]}}, word[21:0]};
      res     = '0;
      wr      = 1'b1;
      next_pc = model_pc + 32'd4;
      out_expected_cnt = 0;
      case (op)
         ADD:  res = a + b;
         SUB:  res = a - b;
         AND:  res = a & b;
         OR:   res = a | b;
         XOR:  res = a ^ b;
         SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ADDI: res = a + imm;
         XORI: res = a ^ imm;
         // the rd field names the second compared register
         BEQ, BNE: begin
            wr = 1'b0;
            if ((a == c) != (op == BNE)) begin
               next_pc = model_pc + {imm[29:0], 2'b00};
            end
         end
         OUT: begin
            wr                = 1'b0;
            out_expected_cnt  = 1;
            out_expected_data = a;
         end
         default: wr = 1'b0;
      endcase
      if (wr && rd != 3'd0) begin
         model_regs[rd] = res;
      end
      model_pc = next_pc;
   endtask

   // answer one fetch after a random delay of 0 to 3 cycles
   task fetch_one(input logic [31:0] word);
      logic [31:0] rnd;
      logic [31:0] delay;
      wait_fetch();
      if (!aborted) begin
         check_fetch_adr();
         rnd   = $random(seed);
         delay = {30'd0, rnd[1:0]};
         repeat (delay) begin
            tick();
            if (o_ibus_cyc !== 1'b1) begin
               $display("ERROR: o_ibus_cyc dropped before the acknowledge at %0t", $time);
               protocol_cnt = protocol_cnt + 1;
            end
            check_fetch_adr();
         end
         check_out_count();
         out_seen   = 0;
         i_ibus_ack = 1'b1;
         i_ibus_rdt = word;
         tick();
         i_ibus_ack = 1'b0;
         // junk on the data lines must not reach the core
         i_ibus_rdt = $random(seed);
         if (o_ibus_cyc !== 1'b0) begin
            $display("ERROR: o_ibus_cyc still high after the acknowledge at %0t", $time);
            protocol_cnt = protocol_cnt + 1;
         end
         model_step(word);
         if (out_expected_cnt != 0) begin
            wait_out_valid();
         end
      end
   endtask

   initial begin
      logic [31:0] word;
      i_clk             = 1'b0;
      i_rst             = 1'b1;
      i_ibus_ack        = 1'b0;
      i_ibus_rdt        = '0;
      seed              = 32'hfaadaa77;
      mismatch_cnt      = 0;
      protocol_cnt      = 0;
      timeout_cnt       = 0;
      aborted           = 1'b0;
      out_seen          = 0;
      out_expected_cnt  = 0;
      out_expected_data = '0;
      model_pc          = '0;
      slt_pending       = 1'b0;
      slt_rd            = 3'd0;
      for (int k = 0; k < `BITSER_NREGS; k++) begin
         model_regs[k] = '0;
      end

      // no fetch and no output strobe while reset is held
      repeat (8) begin
         tick();
         if (o_ibus_cyc !== 1'b0 || o_out_valid !== 1'b0) begin
            $display("ERROR: bus or output active during reset at %0t", $time);
            protocol_cnt = protocol_cnt + 1;
         end
      end
      i_rst    = 1'b0;
      out_seen = 0;

      for (int k = 1; k <= NUM_SEED_REGS && !aborted; k++) begin
         make_seed_word(k, word);
         fetch_one(word);
      end
      for (int k = 0; k < NUM_RANDOM && !aborted; k++) begin
         make_word(word);
         fetch_one(word);
      end
      // the fetch after the last instruction closes it out
      if (!aborted) begin
         wait_fetch();
         if (!aborted) begin
            check_fetch_adr();
            check_out_count();
         end
      end

      $display("summary: %0d mismatches, %0d protocol errors, %0d timeouts",
               mismatch_cnt, protocol_cnt, timeout_cnt);
      if (mismatch_cnt + protocol_cnt + timeout_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+src
src/bitser_pkg.sv
src/bitser_decode.sv
src/bitser_state.sv
src/bitser_alu.sv
src/bitser_regfile.sv
src/bitser_top.sv
verif/bitser_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the bit-serial core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
   --top-module bitser_tb -o bitser_sim \
   && ./obj_dir/bitser_sim | tee sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
